/* hw/lspcPkg.sv */
// Geometry assumes a 24 MHz master clock, 16-pixel slots and a 384-pixel line; SHRINK_TABLE bit k is slot pixel k
`default_nettype none

package lspcPkg;

	// ====================
	// Dot and line timing
	// ====================

	// Master clocks per pixel, 24 MHz down to 6 MHz
	localparam int DOT_DIV = 4;

	// Full line, render span plus blanking
	localparam int LINE_PIXELS = 384;

	// One sprite slot
	localparam int SLOT_PIXELS = 16;

	// Sixteen slots rendered per line
	localparam int RENDER_PIXELS = 256;

	// Shift-out window, pixels 0 to 319
	localparam int SHIFT_PIXELS = 320;

	// CHG toggles here
	localparam int SWAP_PIXEL = 264;

	// Shift-side address reload, four pixels after the swap
	localparam int RELOAD_PIXEL = 268;

	// ====================
	// Buffer roles
	// ====================

	// Role of one line buffer on the current line
	typedef enum logic
	{
		SIDE_RENDER = 1'b0,
		SIDE_SHIFT = 1'b1
	} bufSide_e;

	// Even half fed by DOTA, odd half by DOTB
	typedef enum logic
	{
		LANE_EVEN = 1'b0,
		LANE_ODD = 1'b1
	} lane_e;

	// ====================
	// H-shrink pattern ROM
	// ====================

	// Entry n keeps n+1 pixels, spread evenly over the slot
	// Entry 15 is full width
	localparam logic [15:0] SHRINK_TABLE [16] = '{
		16'h0080, 16'h0880, 16'h0888, 16'h2888,
		16'h288a, 16'h2a8a, 16'h2aaa, 16'haaaa,
		16'haaea, 16'hbaea, 16'hbaeb, 16'hbbeb,
		16'hbbef, 16'hfbef, 16'hfbff, 16'hffff
	};

endpackage

`default_nettype wire

/* hw/bufferCtrlIf.sv */
// Plain strobes and levels only, no handshake; all request strobes are one master clock wide
`timescale 1ns/1ps
`default_nettype none

// Pixel timing and render decisions, one sequencer to both buffer controllers
interface seqIf
	import lspcPkg::*;
();
	logic chg;
	// Phase 0 of every pixel
	logic pxTick;
	logic pixelOdd;
	// Pixels 0 to 319
	logic shiftWin;
	// Slot start, unchained sprites only
	logic slotLoad;
	logic lineReload;
	// Current pixel survives h-shrink
	logic pxWrite;
	lane_e pxLane;
	// Dot of the selected lane is set
	logic pxOpaque;

	modport seq (output chg, pxTick, pixelOdd, shiftWin, slotLoad, lineReload,
		pxWrite, pxLane, pxOpaque);
	modport ctrl (input chg, pxTick, pixelOdd, shiftWin, slotLoad, lineReload,
		pxWrite, pxLane, pxOpaque);
endinterface

// Requests from one buffer controller to the output strobe stage
interface strobeIf;
	logic weEven;
	logic weOdd;
	logic ckEven;
	logic ckOdd;
	logic ld;
	// Level, shifting out and inside the window
	logic shiftSide;

	modport ctrl (output weEven, weOdd, ckEven, ckOdd, ld, shiftSide);
	modport drv (input weEven, weOdd, ckEven, ckOdd, ld, shiftSide);
endinterface

`default_nettype wire

/* hw/renderSequencer.sv */
// hShrink and chained must be stable at each slot's first phase-0 edge, dotA/dotB at every pixel's
`timescale 1ns/1ps
`default_nettype none

module renderSequencer
	import lspcPkg::*;
#(
	parameter int LINE_PIXELS = lspcPkg::LINE_PIXELS,
	parameter int DOT_DIV = lspcPkg::DOT_DIV
)
(
	input logic CLK_24M,
	input logic T73A_OUT,
	input logic [3:0] hShrink,
	input logic chained,
	input logic dotA,
	input logic dotB,
	seqIf.seq seq
);

	localparam int PhaseW = (DOT_DIV > 1) ? $clog2(DOT_DIV) : 1;
	localparam int PixelW = $clog2(LINE_PIXELS);
	localparam int SlotW = $clog2(SLOT_PIXELS);
	localparam logic [PhaseW-1:0] LastPhase = PhaseW'(DOT_DIV - 1);
	localparam logic [PixelW-1:0] LastPixel = PixelW'(LINE_PIXELS - 1);
	localparam logic [PixelW-1:0] RenderEnd = PixelW'(RENDER_PIXELS);
	localparam logic [PixelW-1:0] ShiftEnd = PixelW'(SHIFT_PIXELS);
	localparam logic [PixelW-1:0] SwapPx = PixelW'(SWAP_PIXEL);
	localparam logic [PixelW-1:0] ReloadPx = PixelW'(RELOAD_PIXEL);

	logic [PhaseW-1:0] phase;
	logic [PixelW-1:0] pixel;
	logic chgQ;
	logic [15:0] shrinkRow;
	lane_e parity;

	logic pxTick;
	logic inRender;
	logic [SlotW-1:0] slotPos;
	logic slotStart;
	logic unchainedStart;
	logic [15:0] rowNow;
	lane_e laneNow;
	logic writeNow;

	// ====================
	// Dot divider and pixel counter
	// ====================

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			phase <= '0;
			pixel <= '0;
		end
		else if (phase == LastPhase)
		begin
			phase <= '0;
			// Wrap at end of line
			pixel <= (pixel == LastPixel) ? '0 : pixel + 1'b1;
		end
		else
			phase <= phase + 1'b1;
	end

	assign pxTick = (phase == '0);
	assign inRender = (pixel < RenderEnd);
	assign slotPos = pixel[SlotW-1:0];

	// Buffer swap, once per line
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
			chgQ <= 1'b0;
		else if (pxTick && (pixel == SwapPx))
			chgQ <= ~chgQ;
	end

	// ====================
	// Slot and shrink pattern
	// ====================

	assign slotStart = pxTick && inRender && (slotPos == '0);
	assign unchainedStart = slotStart && !chained;

	// First pixel of a slot reads the ROM row directly, the rest use the latched copy
	assign rowNow = slotStart ? SHRINK_TABLE[hShrink] : shrinkRow;

	always_ff @(posedge CLK_24M)
	begin
		if (slotStart)
			shrinkRow <= SHRINK_TABLE[hShrink];
	end

	assign writeNow = pxTick && inRender && rowNow[slotPos];

	// Lane parity, restarts even on unchained sprites
	assign laneNow = unchainedStart ? LANE_EVEN : parity;

	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
			parity <= LANE_EVEN;
		else if (pxTick && inRender)
		begin
			// Skipped pixels leave parity alone
			if (writeNow)
				parity <= (laneNow == LANE_EVEN) ? LANE_ODD : LANE_EVEN;
			else
				parity <= laneNow;
		end
	end

	// ====================
	// To the buffer controllers
	// ====================

	assign seq.chg = chgQ;
	assign seq.pxTick = pxTick;
	assign seq.pixelOdd = pixel[0];
	assign seq.shiftWin = (pixel < ShiftEnd);
	assign seq.slotLoad = unchainedStart;
	assign seq.lineReload = pxTick && (pixel == ReloadPx);
	assign seq.pxWrite = writeNow;
	assign seq.pxLane = laneNow;
	// DOTA feeds the even lane, DOTB the odd one
	assign seq.pxOpaque = (laneNow == LANE_EVEN) ? dotA : dotB;

endmodule

`default_nettype wire

/* hw/lineBufferCtrl.sv */
// BUF_INDEX 0 is buffer A, 1 is buffer B; role follows CHG one master clock late, requests only at phase 0
`timescale 1ns/1ps
`default_nettype none

module lineBufferCtrl
	import lspcPkg::*;
#(
	parameter int BUF_INDEX = 0
)
(
	input logic CLK_24M,
	input logic T73A_OUT,
	seqIf.ctrl seq,
	strobeIf.ctrl strb
);

	// Buffer B sees CHG inverted
	localparam logic BufBit = 1'(BUF_INDEX);

	bufSide_e side;
	logic renderHit;
	logic clearTick;
	logic evenReq;
	logic oddReq;

	// ====================
	// Role flop
	// ====================

	// A renders while CHG is low, B shifts out
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
			side <= bufSide_e'(BufBit);
		else
			side <= bufSide_e'(seq.chg ^ BufBit);
	end

	// Opaque pixels only
	assign renderHit = seq.pxWrite && seq.pxOpaque;

	// Clear-after-read, one pixel per tick in the window
	assign clearTick = seq.pxTick && seq.shiftWin;

	// ====================
	// Request select
	// ====================

	always_comb
	begin
		evenReq = 1'b0;
		oddReq = 1'b0;
		strb.ld = 1'b0;
		if (side == SIDE_RENDER)
		begin
			evenReq = renderHit && (seq.pxLane == LANE_EVEN);
			oddReq = renderHit && (seq.pxLane == LANE_ODD);
			// Address load at each unchained slot
			strb.ld = seq.slotLoad;
		end
		else
		begin
			// Lanes alternate with pixel parity
			evenReq = clearTick && !seq.pixelOdd;
			oddReq = clearTick && seq.pixelOdd;
			strb.ld = seq.lineReload;
		end
	end

	// Write and clock pulse together in both roles
	assign strb.weEven = evenReq;
	assign strb.ckEven = evenReq;
	assign strb.weOdd = oddReq;
	assign strb.ckOdd = oddReq;

	// Drives SS of this buffer
	assign strb.shiftSide = (side == SIDE_SHIFT) && seq.shiftWin;

endmodule

`default_nettype wire

/* hw/strobeDriver.sv */
// we/ck bits 0/1 are buffer A even/odd, 2/3 buffer B even/odd; pulses are one master clock, one clock late
`timescale 1ns/1ps
`default_nettype none

module strobeDriver
(
	input logic CLK_24M,
	input logic T73A_OUT,
	strobeIf.drv strb [2],
	output logic [3:0] we,
	output logic [3:0] ck,
	output logic ld1,
	output logic ld2,
	output logic ss1,
	output logic ss2
);

	logic [3:0] weReq;
	logic [3:0] ckReq;
	logic [1:0] ldReq;
	logic [1:0] ssReq;

	// Gather both controllers, A in the low bits
	for (genvar b = 0; b < 2; b++)
	begin : gReq
		assign weReq[2*b] = strb[b].weEven;
		assign weReq[2*b+1] = strb[b].weOdd;
		assign ckReq[2*b] = strb[b].ckEven;
		assign ckReq[2*b+1] = strb[b].ckOdd;
		assign ldReq[b] = strb[b].ld;
		assign ssReq[b] = strb[b].shiftSide;
	end

	// ====================
	// Output latch
	// ====================

	// Requests last one clock, so WE/CK drop for the phase 1 clock only
	always_ff @(posedge CLK_24M or negedge T73A_OUT)
	begin
		if (!T73A_OUT)
		begin
			// Idle, strobes high and no loads
			we <= 4'b1111;
			ck <= 4'b1111;
			ld1 <= 1'b0;
			ld2 <= 1'b0;
			ss1 <= 1'b0;
			ss2 <= 1'b0;
		end
		else
		begin
			we <= ~weReq;
			ck <= ~ckReq;
			ld1 <= ldReq[0];
			ld2 <= ldReq[1];
			ss1 <= ssReq[0];
			ss2 <= ssReq[1];
		end
	end

endmodule

`default_nettype wire

/* hw/lspcLineBuf.sv */
// External line buffers always accept; we/ck active low, first edge after reset release is pixel 0 phase 0
`timescale 1ns/1ps
`default_nettype none

module lspcLineBuf
	import lspcPkg::*;
#(
	parameter int LINE_PIXELS = lspcPkg::LINE_PIXELS,
	parameter int DOT_DIV = lspcPkg::DOT_DIV
)
(
	input logic CLK_24M,
	input logic T73A_OUT,
	input logic [3:0] hShrink,
	input logic chained,
	input logic dotA,
	input logic dotB,
	output logic chg,
	output logic ld1,
	output logic ld2,
	output logic ss1,
	output logic ss2,
	output logic [3:0] we,
	output logic [3:0] ck
);

	seqIf seqBus ();
	// One request bundle per buffer, A then B
	strobeIf strbBus [2] ();

	// ====================
	// Timing and slot sequencing
	// ====================

	renderSequencer #(
		.LINE_PIXELS (LINE_PIXELS),
		.DOT_DIV (DOT_DIV)
	) renderSequencer_i (
		.CLK_24M (CLK_24M),
		.T73A_OUT (T73A_OUT),
		.hShrink (hShrink),
		.chained (chained),
		.dotA (dotA),
		.dotB (dotB),
		.seq (seqBus)
	);

	assign chg = seqBus.chg;

	// Buffer A and buffer B controllers
	for (genvar b = 0; b < 2; b++)
	begin : gBuf
		lineBufferCtrl #(
			.BUF_INDEX (b)
		) lineBufferCtrl_i (
			.CLK_24M (CLK_24M),
			.T73A_OUT (T73A_OUT),
			.seq (seqBus),
			.strb (strbBus[b])
		);
	end

	strobeDriver strobeDriver_i (
		.CLK_24M (CLK_24M),
		.T73A_OUT (T73A_OUT),
		.strb (strbBus),
		.we (we),
		.ck (ck),
		.ld1 (ld1),
		.ld2 (ld2),
		.ss1 (ss1),
		.ss2 (ss2)
	);

endmodule

`default_nettype wire

/* tb/lspcLineBufTb.sv */
// Random hShrink/chained per slot and dots per pixel, fixed seed; runs six lines and stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

module lspcLineBufTb
	import lspcPkg::*;
();

	localparam int CLK_PERIOD = 10;
	localparam int RESET_CYCLES = 8;
	localparam int LINES = 6;
	localparam int LINE_CLKS = LINE_PIXELS * DOT_DIV;
	localparam int SLOT_CLKS = SLOT_PIXELS * DOT_DIV;
	// Six lines, reset and a little slack
	localparam int TIMEOUT_NS = (RESET_CYCLES + LINES * LINE_CLKS + 100) * CLK_PERIOD;

	logic CLK_24M;
	logic T73A_OUT;
	logic [3:0] hShrink;
	logic chained;
	logic dotA;
	logic dotB;
	logic chg;
	logic ld1;
	logic ld2;
	logic ss1;
	logic ss2;
	logic [3:0] we;
	logic [3:0] ck;

	integer seed = 32'h53bd_9acf;

	// Reference model state, current cycle
	int mPhase = 0;
	int mPixel = 0;
	logic mChg = 1'b0;
	// Buffer role follows chg one clock late
	logic mRole = 1'b0;
	logic [15:0] mRow = '0;
	lane_e mParity = LANE_EVEN;

	// Expected registered outputs, reset values first
	logic [3:0] expWe = 4'b1111;
	logic [3:0] expCk = 4'b1111;
	logic [1:0] expLd = 2'b00;
	logic [1:0] expSs = 2'b00;

	// Pulses seen on the DUT outputs, index 0 is A
	int renderHits [2] = '{0, 0};
	int clearHits [2] = '{0, 0};
	int shiftLds [2] = '{0, 0};
	int chgToggles = 0;
	logic lastChg = 1'b0;

	lspcLineBuf lspcLineBuf_i (
		.CLK_24M (CLK_24M),
		.T73A_OUT (T73A_OUT),
		.hShrink (hShrink),
		.chained (chained),
		.dotA (dotA),
		.dotB (dotB),
		.chg (chg),
		.ld1 (ld1),
		.ld2 (ld2),
		.ss1 (ss1),
		.ss2 (ss2),
		.we (we),
		.ck (ck)
	);

	always #(CLK_PERIOD / 2) CLK_24M = ~CLK_24M;

	// ====================
	// Error reporting
	// ====================

	task automatic valueFail(input string name, input logic [3:0] exp, input logic [3:0] got);
		$display("[FAIL] %0t ns: %s is %b, expected %b (pixel %0d phase %0d)",
			$time, name, got, exp, mPixel, mPhase);
		$display("TEST FAILED");
		$fatal(1, "output mismatch");
	endtask

	task automatic countFail(input string name, input int got, input int exp);
		$display("[FAIL] %0t ns: %s counted %0d, expected %0d", $time, name, got, exp);
		$display("TEST FAILED");
		$fatal(1, "count mismatch");
	endtask

	task automatic roleFail(input int b);
		$display("Buffer %s was not exercised in both render and shift-out roles",
			(b == 0) ? "A" : "B");
		$display("TEST FAILED");
		$fatal(1, "coverage hole");
	endtask

	// ====================
	// Stimulus
	// ====================

	// New sprite attributes, sampled at slot start
	task automatic drawSlot();
		int r;
		r = $random(seed);
		hShrink = r[3:0];
		chained = r[4];
	endtask

	// New pixel pair for both lanes
	task automatic drawDots();
		int r;
		r = $random(seed);
		dotA = r[0];
		dotB = r[1];
	endtask

	// ====================
	// Reference model
	// ====================

	// One rising edge ahead, using the inputs held for that edge
	task automatic stepModel();
		logic tick;
		int slotPos;
		logic slotStart;
		logic unchained;
		logic [15:0] row;
		lane_e lane;
		logic keep;
		logic opaque;
		int rBuf;
		int sBuf;
		logic [3:0] req;
		logic [1:0] ldReq;
		logic [1:0] ssReq;
		tick = (mPhase == 0);
		req = '0;
		ldReq = '0;
		ssReq = '0;
		// A renders while the role is 0
		rBuf = mRole ? 1 : 0;
		sBuf = 1 - rBuf;
		slotPos = mPixel % SLOT_PIXELS;
		// Render side, slots 0 to 15
		if (tick && (mPixel < RENDER_PIXELS))
		begin
			slotStart = (slotPos == 0);
			unchained = slotStart && !chained;
			row = slotStart ? SHRINK_TABLE[hShrink] : mRow;
			if (slotStart)
				mRow = row;
			lane = unchained ? LANE_EVEN : mParity;
			keep = row[slotPos];
			opaque = (lane == LANE_EVEN) ? dotA : dotB;
			// Transparent dots consume a lane but write nothing
			if (keep && opaque)
				req[2 * rBuf + int'(lane)] = 1'b1;
			if (keep)
				mParity = (lane == LANE_EVEN) ? LANE_ODD : LANE_EVEN;
			else
				mParity = lane;
			if (unchained)
				ldReq[rBuf] = 1'b1;
		end
		// Clear after read, lane from pixel parity
		if (tick && (mPixel < SHIFT_PIXELS))
			req[2 * sBuf + (mPixel % 2)] = 1'b1;
		if (tick && (mPixel == RELOAD_PIXEL))
			ldReq[sBuf] = 1'b1;
		if (mPixel < SHIFT_PIXELS)
			ssReq[sBuf] = 1'b1;
		// Registered, active-low strobes
		expWe = ~req;
		expCk = ~req;
		expLd = ldReq;
		expSs = ssReq;
		mRole = mChg;
		if (tick && (mPixel == SWAP_PIXEL))
			mChg = ~mChg;
		if (mPhase == DOT_DIV - 1)
		begin
			mPhase = 0;
			mPixel = (mPixel == LINE_PIXELS - 1) ? 0 : mPixel + 1;
		end
		else
			mPhase++;
	endtask

	task automatic compareOutputs();
		assert (we === expWe) else valueFail("we", expWe, we);
		assert (ck === expCk) else valueFail("ck", expCk, ck);
		assert (ld1 === expLd[0]) else valueFail("ld1", {3'b0, expLd[0]}, {3'b0, ld1});
		assert (ld2 === expLd[1]) else valueFail("ld2", {3'b0, expLd[1]}, {3'b0, ld2});
		assert (ss1 === expSs[0]) else valueFail("ss1", {3'b0, expSs[0]}, {3'b0, ss1});
		assert (ss2 === expSs[1]) else valueFail("ss2", {3'b0, expSs[1]}, {3'b0, ss2});
		assert (chg === mChg) else valueFail("chg", {3'b0, mChg}, {3'b0, chg});
	endtask

	// Count DUT pulses per buffer, SS marks the shift-out buffer
	task automatic tallyPulses();
		logic [1:0] ss;
		logic [1:0] ld;
		ss = {ss2, ss1};
		ld = {ld2, ld1};
		if (chg !== lastChg)
			chgToggles++;
		lastChg = chg;
		for (int b = 0; b < 2; b++)
		begin
			if (ss[b] === 1'b1)
			begin
				if (ck[2 * b] === 1'b0)
					clearHits[b]++;
				if (ck[2 * b + 1] === 1'b0)
					clearHits[b]++;
				if (ld[b] === 1'b1)
					shiftLds[b]++;
			end
			else
			begin
				if (we[2 * b] === 1'b0)
					renderHits[b]++;
				if (we[2 * b + 1] === 1'b0)
					renderHits[b]++;
			end
		end
	endtask

	// Outputs settle well before the falling edge
	always @(negedge CLK_24M)
	begin
		if (T73A_OUT === 1'b1)
		begin
			compareOutputs();
			tallyPulses();
			stepModel();
		end
	end

	// ====================
	// Main sequence
	// ====================

	initial
	begin
		CLK_24M = 1'b0;
		T73A_OUT = 1'b0;
		drawSlot();
		drawDots();
		repeat (RESET_CYCLES) @(posedge CLK_24M);
		#1;
		T73A_OUT = 1'b1;
		// Edge n after release belongs to pixel n / DOT_DIV
		for (int n = 1; n <= LINES * LINE_CLKS; n++)
		begin
			@(posedge CLK_24M);
			#1;
			if (n % SLOT_CLKS == 0)
				drawSlot();
			if (n % DOT_DIV == 0)
				drawDots();
		end
		assert (chgToggles == LINES) else countFail("chg toggles", chgToggles, LINES);
		assert (clearHits[0] + clearHits[1] == LINES * SHIFT_PIXELS)
			else countFail("clear pulses", clearHits[0] + clearHits[1], LINES * SHIFT_PIXELS);
		assert (shiftLds[0] + shiftLds[1] == LINES)
			else countFail("shift-side loads", shiftLds[0] + shiftLds[1], LINES);
		for (int b = 0; b < 2; b++)
		begin
			assert ((renderHits[b] > 0) && (clearHits[b] > 0)) else roleFail(b);
		end
		$display("TEST PASSED");
		$finish;
	end

	// Watchdog
	initial
	begin
		#(TIMEOUT_NS);
		$display("Watchdog timeout, the run did not finish in time");
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

endmodule

`default_nettype wire

/* src.f */
hw/lspcPkg.sv
hw/bufferCtrlIf.sv
hw/renderSequencer.sv
hw/lineBufferCtrl.sv
hw/strobeDriver.sv
hw/lspcLineBuf.sv
tb/lspcLineBufTb.sv

/* Makefile */
# Verilator build and run of the line-buffer control testbench

VERILATOR ?= verilator
TOP ?= lspcLineBufTb
FILELIST ?= src.f
MDIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -Wno-fatal -j 0
PASS_MSG ?= TEST PASSED

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(MDIR)
	./$(MDIR)/V$(TOP) | tee /dev/stderr | grep "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(MDIR)
